// ==== tb/usb_tx_golden.txt ====
# group tag(H/D) pid npay payload... nexp expected bytes after SYNC (PID, payload, CRC lo, CRC hi)
# rows of one group are requested in the same cycle, all values hex except the two counts
1 H 2 0 1 D2
2 D 3 9 31 32 33 34 35 36 37 38 39 12 C3 31 32 33 34 35 36 37 38 39 C8 B4
3 D B 3 FF FF FF 6 4B FF FF FF BF BF
4 H A 0 1 5A
4 D 3 5 FF FF FF FF FF 8 C3 FF FF FF FF FF CE 7F
5 D B 9 31 32 33 34 35 36 37 38 39 12 4B 31 32 33 34 35 36 37 38 39 C8 B4
6 D 3 5 FF FF FF FF FF 8 C3 FF FF FF FF FF CE 7F
7 H E 0 1 1E

// ==== all.f ====
+incdir+common
common/usb_pkg.sv
source/usb_tx_arbiter.sv
packet/usb_packetizer.sv
source/usb_byte_queue.sv
line/usb_line_tx.sv
source/usb_tx_top.sv
tb/usb_line_monitor.sv
tb/tb_usb_tx.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator, fails if the log reports failure.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_usb_tx -Mdir obj_dir

./obj_dir/Vtb_usb_tx | tee sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

// ==== tb/tb_usb_tx.sv ====
/*
  Testbench for the USB full-speed transmit path.
  Requests and expected packets come from tb/usb_tx_golden.txt, rows of one
  group are raised in the same cycle and expected in file order.
*/
`timescale 1ns/1ps

module tb_usb_tx;

  localparam int WAIT_LIMIT = 20000; // clocks per wait
  localparam int MAX_PKT    = 64;
  localparam int MAX_BYTES  = 32;

  logic               clk;
  logic               rst_n;
  logic               hs_valid;
  usb_pkg::usb_pid_t  hs_pid;
  logic               hs_ready;
  logic               data_valid;
  usb_pkg::usb_pid_t  data_pid;
  logic               data_ready;
  logic               pay_valid;
  usb_pkg::usb_byte_t pay_data;
  logic               pay_last;
  logic               pay_ready;
  logic               dp;
  logic               dn;
  logic               oe;
  logic               busy;

  int                 errors;
  logic               timed_out;
  logic [7:0]         exp_bytes [MAX_PKT][MAX_BYTES];
  int                 exp_len [MAX_PKT];
  int                 exp_count;
  logic               grp_hs;      // group holds a handshake request
  usb_pkg::usb_pid_t  grp_hs_pid;
  logic               grp_d;       // group holds a data request
  usb_pkg::usb_pid_t  grp_d_pid;
  logic [7:0]         grp_pay [MAX_BYTES];
  int                 grp_pay_len;

  usb_tx_top usb_tx_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .hs_valid   (hs_valid),
    .hs_pid     (hs_pid),
    .hs_ready   (hs_ready),
    .data_valid (data_valid),
    .data_pid   (data_pid),
    .data_ready (data_ready),
    .pay_valid  (pay_valid),
    .pay_data   (pay_data),
    .pay_last   (pay_last),
    .pay_ready  (pay_ready),
    .dp         (dp),
    .dn         (dn),
    .oe         (oe),
    .busy       (busy)
  );

  usb_line_monitor line_monitor_i (
    .clk   (clk),
    .rst_n (rst_n),
    .dp    (dp),
    .dn    (dn),
    .oe    (oe)
  );

  always #20 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    errors++;
    timed_out = 1'b1;
  endtask

  task automatic send_payload();
    int i;
    int n;
    for (i = 0; i < grp_pay_len && !timed_out; i++)
    begin
      pay_valid = 1'b1;
      pay_data  = grp_pay[i];
      pay_last  = (i == grp_pay_len - 1);
      n = 0;
      #1;
      while (!pay_ready && n < WAIT_LIMIT)
      begin
        @(negedge clk);
        #1;
        n++;
      end
      if (!pay_ready)
        report_timeout("pay_ready");
      @(negedge clk); // byte taken on the rising edge in between
    end
    pay_valid = 1'b0;
    pay_last  = 1'b0;
  endtask

  task automatic issue_group();
    int   n;
    logic hs_take;
    logic d_take;
    hs_valid   = grp_hs;
    hs_pid     = grp_hs_pid;
    data_valid = grp_d;
    data_pid   = grp_d_pid;
    n = 0;
    while ((hs_valid || data_valid) && !timed_out)
    begin
      #1;
      hs_take = hs_ready;
      d_take  = data_ready;
      @(negedge clk);
      if (hs_take)
        hs_valid = 1'b0;
      if (d_take)
      begin
        data_valid = 1'b0;
        send_payload();
      end
      n++;
      if (n > WAIT_LIMIT)
        report_timeout("hs_ready or data_ready");
    end
    hs_valid   = 1'b0;
    data_valid = 1'b0;
    grp_hs     = 1'b0;
    grp_d      = 1'b0;
  endtask

  task automatic run_golden();
    int    fd;
    int    r;
    int    group;
    int    cur_group;
    int    npay;
    int    nexp;
    int    v;
    int    i;
    int    pid_v;
    string tok;
    string tag;
    string rest;
    fd = $fopen("tb/usb_tx_golden.txt", "r");
    if (fd == 0)
    begin
      $display("could not open tb/usb_tx_golden.txt");
      errors++;
      return;
    end
    cur_group = -1;
    while (!$feof(fd) && !timed_out)
    begin
      r = $fscanf(fd, "%s", tok);
      if (r != 1)
        break;
      if (tok.substr(0, 0) == "#")
      begin
        r = $fgets(rest, fd); // comment line
        continue;
      end
      group = tok.atoi();
      if (group != cur_group && cur_group >= 0)
        issue_group();
      cur_group = group;
      r = $fscanf(fd, " %s %h %d", tag, pid_v, npay);
      if (tag == "H")
      begin
        grp_hs     = 1'b1;
        grp_hs_pid = 4'(pid_v);
      end
      else
      begin
        grp_d       = 1'b1;
        grp_d_pid   = 4'(pid_v);
        grp_pay_len = npay;
      end
      for (i = 0; i < npay; i++)
      begin
        r = $fscanf(fd, " %h", v);
        if (i < MAX_BYTES)
          grp_pay[i] = 8'(v);
      end
      r = $fscanf(fd, " %d", nexp);
      exp_len[exp_count] = nexp;
      for (i = 0; i < nexp; i++)
      begin
        r = $fscanf(fd, " %h", v);
        if (i < MAX_BYTES)
          exp_bytes[exp_count][i] = 8'(v);
      end
      exp_count++;
    end
    if (cur_group >= 0 && !timed_out)
      issue_group();
    $fclose(fd);
  endtask

  task automatic wait_line_done();
    int n;
    n = 0;
    while (line_monitor_i.pkt_count < exp_count && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (line_monitor_i.pkt_count < exp_count)
      report_timeout("all packets on the line");
    else
      check_value("busy", busy, 1'b1); // final J bit still on the line
    n = 0;
    while (busy && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (busy)
      report_timeout("busy to fall");
    else
    begin
      check_value("oe", oe, 1'b0);
      check_value("dp", dp, 1'b1);
      check_value("dn", dn, 1'b0);
    end
  endtask

  task automatic compare_packets();
    int i;
    int j;
    int npkt;
    check_value("packet count", line_monitor_i.pkt_count, exp_count);
    npkt = (line_monitor_i.pkt_count < exp_count) ? line_monitor_i.pkt_count : exp_count;
    for (i = 0; i < npkt; i++)
    begin
      check_value($sformatf("packet %0d length", i), line_monitor_i.pkt_len[i], exp_len[i]);
      for (j = 0; j < exp_len[i] && j < line_monitor_i.pkt_len[i] && j < MAX_BYTES; j++)
        check_value($sformatf("packet %0d byte %0d", i, j),
                    line_monitor_i.pkt_bytes[i][j], exp_bytes[i][j]);
    end
  endtask

  initial
  begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    hs_valid   = 1'b0;
    hs_pid     = '0;
    data_valid = 1'b0;
    data_pid   = '0;
    pay_valid  = 1'b0;
    pay_data   = '0;
    pay_last   = 1'b0;
    errors     = 0;
    timed_out  = 1'b0;
    exp_count  = 0;
    grp_hs     = 1'b0;
    grp_d      = 1'b0;
    grp_pay_len = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    #1;
    // idle line after reset
    check_value("oe", oe, 1'b0);
    check_value("busy", busy, 1'b0);
    check_value("dp", dp, 1'b1);
    check_value("dn", dn, 1'b0);
    check_value("hs_ready", hs_ready, 1'b0);
    check_value("data_ready", data_ready, 1'b0);
    check_value("pay_ready", pay_ready, 1'b0);
    @(negedge clk);
    run_golden();
    if (!timed_out)
      wait_line_done();
    if (!timed_out)
      compare_packets();
    $display("errors: %0d in checks, %0d in line monitor", errors, line_monitor_i.errors);
    if (errors + line_monitor_i.errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// ==== tb/usb_line_monitor.sv ====
/*
  Decodes dp/dn back into packet bytes (NRZI, destuffing, SYNC check, EOP).
  The first bit of a packet is aligned to the rise of oe.
  Holds at most 64 packets of 32 bytes after SYNC.
*/
`timescale 1ns/1ps
`include "usb_settings.svh"

module usb_line_monitor (
  input logic clk,
  input logic rst_n,
  input logic dp,
  input logic dn,
  input logic oe
);

  logic [7:0] pkt_bytes [64][32]; // decoded bytes after SYNC
  int         pkt_len [64];
  int         pkt_count;
  int         errors;

  logic       in_pkt;
  logic       wait_idle;  // packet ended while oe is high
  int         phase;      // clock within the current bit
  logic [1:0] prev;       // previous line state {dp, dn}
  int         ones;
  int         se0_cnt;
  logic [7:0] sh;
  int         nbits;
  int         nbytes;
  logic       got_sync;

  task automatic store_byte();
    if (!got_sync)
    begin
      got_sync = 1'b1;
      if (sh != `USB_SYNC_BYTE)
      begin
        $display("** Error sync byte of packet %0d: got 0x%0h, expected 0x%0h",
                 pkt_count, sh, `USB_SYNC_BYTE);
        errors++;
      end
    end
    else
    begin
      if (nbytes < 32 && pkt_count < 64)
        pkt_bytes[pkt_count][nbytes] = sh;
      nbytes++;
    end
  endtask

  task automatic finish_packet();
    if (nbits != 0)
    begin
      $display("line monitor: packet %0d ended in the middle of a byte", pkt_count);
      errors++;
    end
    if (pkt_count < 64)
      pkt_len[pkt_count] = nbytes;
    pkt_count++;
  endtask

  task automatic sample_bit(input logic [1:0] line);
    logic b;
    if (line == 2'b00)
      se0_cnt++;
    else if (se0_cnt > 0)
    begin
      if (se0_cnt != 2 || line != 2'b10)
      begin
        $display("line monitor: packet %0d has a malformed end of packet", pkt_count);
        errors++;
      end
      finish_packet();
      in_pkt    = 1'b0;
      wait_idle = 1'b1;
    end
    else
    begin
      if (line == 2'b11)
      begin
        $display("line monitor: both dp and dn high inside packet %0d", pkt_count);
        errors++;
      end
      b    = (line == prev); // no transition is a one
      prev = line;
      if (ones == 6)
      begin
        if (b)
        begin
          $display("line monitor: stuffing violation, seven ones in packet %0d", pkt_count);
          errors++;
        end
        ones = 0; // stuffed bit dropped
      end
      else
      begin
        ones  = b ? ones + 1 : 0;
        sh    = {b, sh[7:1]}; // LSB first
        nbits = nbits + 1;
        if (nbits == 8)
        begin
          store_byte();
          nbits = 0;
        end
      end
    end
  endtask

  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      in_pkt    = 1'b0;
      wait_idle = 1'b0;
      pkt_count = 0;
      errors    = 0;
    end
    else if (!in_pkt)
    begin
      if (!oe)
        wait_idle = 1'b0;
      else if (!wait_idle)
      begin
        in_pkt   = 1'b1;
        phase    = 1; // first half clock of bit already gone
        prev     = 2'b10;
        ones     = 0;
        se0_cnt  = 0;
        nbits    = 0;
        nbytes   = 0;
        got_sync = 1'b0;
      end
    end
    else
    begin
      if (phase == 1)
        sample_bit({dp, dn}); // middle of the bit
      phase = (phase + 1) % `USB_BIT_PERIOD;
    end
  end

endmodule

// ==== source/usb_tx_top.sv ====
/*
  Transmit side of a USB full-speed device.
  The line leaves as separate dp, dn and oe, the pad tristate sits outside.
*/
`timescale 1ns/1ps

module usb_tx_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               hs_valid,
  input  usb_pkg::usb_pid_t  hs_pid,
  output logic               hs_ready,
  input  logic               data_valid,
  input  usb_pkg::usb_pid_t  data_pid,
  output logic               data_ready,
  input  logic               pay_valid,
  input  usb_pkg::usb_byte_t pay_data,
  input  logic               pay_last,
  output logic               pay_ready,
  output logic               dp,
  output logic               dn,
  output logic               oe,
  output logic               busy
);

  logic                req_valid;
  usb_pkg::usb_req_s   req;
  logic                req_take;
  logic                pkt_done;
  logic                pp_valid;
  usb_pkg::usb_byte_t  pp_data;
  logic                pp_last;
  logic                pp_ready;
  logic                q_push;
  usb_pkg::usb_qbyte_s q_byte;
  logic                credit_return;
  logic                q_valid;
  usb_pkg::usb_qbyte_s q_head;
  logic                q_rd;

  usb_tx_arbiter usb_tx_arbiter_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .hs_valid   (hs_valid),
    .hs_pid     (hs_pid),
    .hs_ready   (hs_ready),
    .data_valid (data_valid),
    .data_pid   (data_pid),
    .data_ready (data_ready),
    .pay_valid  (pay_valid),
    .pay_data   (pay_data),
    .pay_last   (pay_last),
    .pay_ready  (pay_ready),
    .req_valid  (req_valid),
    .req        (req),
    .req_take   (req_take),
    .pkt_done   (pkt_done),
    .pp_valid   (pp_valid),
    .pp_data    (pp_data),
    .pp_last    (pp_last),
    .pp_ready   (pp_ready)
  );

  usb_packetizer usb_packetizer_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req           (req),
    .req_take      (req_take),
    .pkt_done      (pkt_done),
    .pp_valid      (pp_valid),
    .pp_data       (pp_data),
    .pp_last       (pp_last),
    .pp_ready      (pp_ready),
    .q_push        (q_push),
    .q_byte        (q_byte),
    .credit_return (credit_return)
  );

  usb_byte_queue usb_byte_queue_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .q_push        (q_push),
    .q_byte        (q_byte),
    .q_rd          (q_rd),
    .q_valid       (q_valid),
    .q_head        (q_head),
    .credit_return (credit_return)
  );

  usb_line_tx usb_line_tx_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .q_valid (q_valid),
    .q_head  (q_head),
    .q_rd    (q_rd),
    .dp      (dp),
    .dn      (dn),
    .oe      (oe),
    .busy    (busy)
  );

endmodule

// ==== line/usb_line_tx.sv ====
/*
  NRZI line encoder, LSB first, with a stuffed zero after six ones.
  Each packet ends with 2 SE0 bits and 1 J bit. The queue must not run dry
  inside a packet, only the last flag ends it.
*/
`timescale 1ns/1ps
`include "usb_settings.svh"

module usb_line_tx (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                q_valid,
  input  usb_pkg::usb_qbyte_s q_head,
  output logic                q_rd,
  output logic                dp,
  output logic                dn,
  output logic                oe,
  output logic                busy
);

  localparam int TICK_W = $clog2(`USB_BIT_PERIOD);
  localparam logic [TICK_W-1:0] TICK_RELOAD = TICK_W'(`USB_BIT_PERIOD - 1);

  logic [TICK_W-1:0]  tick;     // clocks left in the current bit
  usb_pkg::usb_byte_t shift;
  logic [2:0]         bits;     // data bits left in the byte
  logic [2:0]         ones;     // consecutive ones sent
  usb_pkg::usb_line_e line;
  usb_pkg::usb_line_e line_toggled;
  logic               last_q;   // byte in flight closes the packet
  logic               eop;
  logic [1:0]         eop_cnt;
  logic               active;
  logic               boundary;
  logic               stuff;
  logic               load;
  logic               send;
  logic               eop_start;
  logic               tx_bit;

  assign boundary  = (tick == '0);
  assign stuff     = boundary && !eop && (ones == 3'(`USB_STUFF_LIMIT));
  assign load      = boundary && !eop && !stuff && (bits == '0) && !last_q && q_valid;
  assign send      = load || (boundary && !eop && !stuff && (bits != '0));
  assign eop_start = boundary && !eop && !stuff && (bits == '0) && last_q;
  assign tx_bit    = load ? q_head.data[0] : shift[0]; // first bit goes out on load

  assign line_toggled = (line == usb_pkg::line_j) ? usb_pkg::line_k : usb_pkg::line_j;

  assign q_rd     = load;
  assign {dp, dn} = line;
  assign oe       = active;
  assign busy     = active;

  always_ff @(posedge clk)
  begin
    if (send)
      shift <= load ? {1'b0, q_head.data[7:1]} : {1'b0, shift[7:1]};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tick    <= '0;
      bits    <= '0;
      ones    <= '0;
      line    <= usb_pkg::line_j; // idle state
      last_q  <= 1'b0;
      eop     <= 1'b0;
      eop_cnt <= '0;
      active  <= 1'b0;
    end
    else if (!boundary)
    begin
      tick <= tick - 1'b1;
    end
    else if (stuff)
    begin
      line <= line_toggled; // stuffed zero
      ones <= '0;
      tick <= TICK_RELOAD;
    end
    else if (send)
    begin
      tick   <= TICK_RELOAD;
      active <= 1'b1;
      bits   <= load ? 3'd7 : bits - 1'b1;
      if (load)
        last_q <= q_head.last;
      if (tx_bit)
        ones <= ones + 1'b1; // one holds the line
      else
      begin
        line <= line_toggled;
        ones <= '0;
      end
    end
    else if (eop_start)
    begin
      line    <= usb_pkg::line_se0;
      eop     <= 1'b1;
      eop_cnt <= '0;
      last_q  <= 1'b0;
      ones    <= '0;
      tick    <= TICK_RELOAD;
    end
    else if (eop)
    begin
      case (eop_cnt)
        2'd0:
        begin
          line    <= usb_pkg::line_se0; // second SE0 bit
          eop_cnt <= 2'd1;
          tick    <= TICK_RELOAD;
        end
        2'd1:
        begin
          line    <= usb_pkg::line_j;
          eop_cnt <= 2'd2;
          tick    <= TICK_RELOAD;
        end
        default:
        begin
          eop     <= 1'b0; // J bit done, release the line
          eop_cnt <= '0;
          active  <= 1'b0;
        end
      endcase
    end
  end

endmodule

// ==== source/usb_byte_queue.sv ====
/*
  Circular byte queue between packetizer and line encoder.
  Writes are not checked against a full queue, the credit count guards it.
*/
`timescale 1ns/1ps
`include "usb_settings.svh"

module usb_byte_queue (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                q_push,
  input  usb_pkg::usb_qbyte_s q_byte,
  input  logic                q_rd,
  output logic                q_valid,
  output usb_pkg::usb_qbyte_s q_head,
  output logic                credit_return
);

  localparam int PTR_W = $clog2(`USB_QUEUE_DEPTH);

  usb_pkg::usb_qbyte_s  mem [`USB_QUEUE_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  usb_pkg::usb_credit_t count;
  logic                 pop;

  assign q_valid = (count != '0);
  assign q_head  = mem[rd_ptr];
  assign pop     = q_rd && q_valid;

  always_ff @(posedge clk)
  begin
    if (q_push)
      mem[wr_ptr] <= q_byte;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end
    else
    begin
      credit_return <= pop; // one credit back per byte read
      if (q_push)
        wr_ptr <= wr_ptr + 1'b1; // wraps at a power-of-two depth
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({q_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== packet/usb_packetizer.sv ====
/*
  Frames SYNC, PID and, for data packets, payload and CRC16 into the byte queue.
  Pushes only while credits remain. A data packet needs at least one payload byte.
*/
`timescale 1ns/1ps
`include "usb_settings.svh"

module usb_packetizer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_valid,
  input  usb_pkg::usb_req_s   req,
  output logic                req_take,
  output logic                pkt_done,
  input  logic                pp_valid,
  input  usb_pkg::usb_byte_t  pp_data,
  input  logic                pp_last,
  output logic                pp_ready,
  output logic                q_push,
  output usb_pkg::usb_qbyte_s q_byte,
  input  logic                credit_return
);

  usb_pkg::usb_pkt_e    state;
  usb_pkg::usb_credit_t credits;
  usb_pkg::usb_pid_t    pid_q;
  logic                 has_pay_q;
  logic [15:0]          crc;
  logic                 credit_ok;

  // serial CRC16, data bits taken LSB first
  function automatic logic [15:0] crc16_byte(input logic [15:0] crc_in,
                                             input usb_pkg::usb_byte_t data);
    logic [15:0] c;
    int          i;
    c = crc_in;
    for (i = 0; i < 8; i++)
    begin
      if (c[0] ^ data[i])
        c = (c >> 1) ^ `USB_CRC16_POLY;
      else
        c = c >> 1;
    end
    return c;
  endfunction

  assign credit_ok = (credits != '0);
  assign req_take  = (state == usb_pkg::idle) && req_valid;
  assign pp_ready  = (state == usb_pkg::payload) && credit_ok;

  always_comb
  begin
    q_push = 1'b0;
    q_byte = '0;
    case (state)
      usb_pkg::sync:
      begin
        q_push      = credit_ok;
        q_byte.data = `USB_SYNC_BYTE;
      end
      usb_pkg::pid:
      begin
        q_push      = credit_ok;
        q_byte.data = {~pid_q, pid_q}; // check nibble on top
        q_byte.last = !has_pay_q;
      end
      usb_pkg::payload:
      begin
        q_push      = credit_ok && pp_valid;
        q_byte.data = pp_data;
      end
      usb_pkg::crc_lo:
      begin
        q_push      = credit_ok;
        q_byte.data = ~crc[7:0]; // sent inverted, low byte first
      end
      usb_pkg::crc_hi:
      begin
        q_push      = credit_ok;
        q_byte.data = ~crc[15:8];
        q_byte.last = 1'b1;
      end
      default:
      begin
        q_push = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= usb_pkg::idle;
      credits  <= usb_pkg::usb_credit_t'(`USB_QUEUE_DEPTH);
      pkt_done <= 1'b0;
    end
    else
    begin
      pkt_done <= q_push && q_byte.last;
      case ({q_push, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits; // none or both cancel out
      endcase
      case (state)
        usb_pkg::idle:    if (req_valid) state <= usb_pkg::sync;
        usb_pkg::sync:    if (q_push) state <= usb_pkg::pid;
        usb_pkg::pid:     if (q_push) state <= has_pay_q ? usb_pkg::payload : usb_pkg::idle;
        usb_pkg::payload: if (q_push && pp_last) state <= usb_pkg::crc_lo;
        usb_pkg::crc_lo:  if (q_push) state <= usb_pkg::crc_hi;
        usb_pkg::crc_hi:  if (q_push) state <= usb_pkg::idle;
        default:          state <= usb_pkg::idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (req_take)
    begin
      pid_q     <= req.pid;
      has_pay_q <= req.has_payload;
      crc       <= `USB_CRC16_INIT;
    end
    else if ((state == usb_pkg::payload) && q_push)
    begin
      crc <= crc16_byte(crc, pp_data);
    end
  end

endmodule

// ==== source/usb_tx_arbiter.sv ====
/*
  Grants the packetizer to one port for a whole packet, handshakes first.
  The grant locks on req_take and releases on pkt_done.
*/
`timescale 1ns/1ps

module usb_tx_arbiter (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                hs_valid,
  input  usb_pkg::usb_pid_t   hs_pid,
  output logic                hs_ready,
  input  logic                data_valid,
  input  usb_pkg::usb_pid_t   data_pid,
  output logic                data_ready,
  input  logic                pay_valid,
  input  usb_pkg::usb_byte_t  pay_data,
  input  logic                pay_last,
  output logic                pay_ready,
  output logic                req_valid,
  output usb_pkg::usb_req_s   req,
  input  logic                req_take,
  input  logic                pkt_done,
  output logic                pp_valid,
  output usb_pkg::usb_byte_t  pp_data,
  output logic                pp_last,
  input  logic                pp_ready
);

  logic locked;   // packet in flight
  logic sel_data; // data port owns the grant

  assign req_valid       = !locked && (hs_valid || data_valid);
  assign req.pid         = hs_valid ? hs_pid : data_pid; // fixed priority
  assign req.has_payload = !hs_valid;

  assign hs_ready   = req_take && hs_valid;
  assign data_ready = req_take && !hs_valid && data_valid;

  // payload only flows while the data port holds the grant
  assign pp_valid  = locked && sel_data && pay_valid;
  assign pp_data   = pay_data;
  assign pp_last   = pay_last;
  assign pay_ready = locked && sel_data && pp_ready;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      locked   <= 1'b0;
      sel_data <= 1'b0;
    end
    else if (req_take)
    begin
      locked   <= 1'b1;
      sel_data <= !hs_valid; // same choice as req above
    end
    else if (pkt_done)
    begin
      locked <= 1'b0;
    end
  end

endmodule

// ==== common/usb_pkg.sv ====
/*
  Types shared by the USB transmit path.
  Line states encode {dp, dn} directly, so J is 2'b10 and K is 2'b01.
*/
`include "usb_settings.svh"

package usb_pkg;

  typedef logic [7:0] usb_byte_t;
  typedef logic [3:0] usb_pid_t;
  typedef logic [$clog2(`USB_QUEUE_DEPTH + 1) - 1:0] usb_credit_t;

  typedef enum logic [1:0] {
    line_se0 = 2'b00,
    line_k   = 2'b01,
    line_j   = 2'b10
  } usb_line_e;

  typedef struct packed {
    usb_byte_t data;
    logic      last; // final byte of the packet
  } usb_qbyte_s;

  typedef struct packed {
    usb_pid_t pid;
    logic     has_payload; // data packet with CRC16
  } usb_req_s;

  typedef enum logic [2:0] {
    idle,
    sync,
    pid,
    payload,
    crc_lo,
    crc_hi
  } usb_pkt_e;

endpackage

// ==== common/usb_settings.svh ====
/*
  Shared constants of the USB full-speed transmitter.
  USB_QUEUE_DEPTH must be a power of two. The CRC polynomial is in reflected form
  for an LSB-first serial update.
*/
`ifndef USB_SETTINGS_SVH
`define USB_SETTINGS_SVH

// clocks per line bit, 48 MHz / 12 Mbps
`define USB_BIT_PERIOD 4

// byte queue entries, also the initial credit count
`define USB_QUEUE_DEPTH 4

// consecutive ones before a stuffed zero
`define USB_STUFF_LIMIT 6

`define USB_CRC16_POLY 16'hA001 // 0x8005 reflected
`define USB_CRC16_INIT 16'hFFFF

`define USB_SYNC_BYTE 8'h80 // KJKJKJKK on the line, LSB first

`endif
